//--- hdl/backend_config.svh
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

`define XLEN 32

`define DMEM_AW 8

`define EXIT_PC 32'hffffff00

`define SP_RESET 32'h00002000

`endif

//--- hdl/backend_pkg.sv
package backend_pkg;

    typedef enum logic [3:0] {
        WB_ALU   = 4'd0,
        WB_MEMB  = 4'd1,
        WB_MEMBU = 4'd2,
        WB_MEMH  = 4'd3,
        WB_MEMHU = 4'd4,
        WB_MEMW  = 4'd5,
        WB_PC    = 4'd6,
        WB_CSR   = 4'd7
    } wb_sel_e;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_READ = 2'd1,
        ARB_ACK  = 2'd2
    } arb_state_e;

    // LD_DONE also covers a non-load that is being handed to writeback
    typedef enum logic [1:0] {
        LD_EMPTY = 2'd0,
        LD_HOLD  = 2'd1,
        LD_REQ   = 2'd2,
        LD_DONE  = 2'd3
    } load_state_e;

endpackage

//--- hdl/mem_req_if.sv
`include "backend_config.svh"

interface mem_req_if;

    logic               req;
    logic               ack;
    logic               we;
    logic [`DMEM_AW-1:0] addr;   // Word address
    logic [`XLEN-1:0]   wdata;
    logic [`XLEN-1:0]   rdata;   // Valid while ack is high

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

//--- hdl/data_mem.sv
`include "backend_config.svh"

module data_mem #(
    parameter int AW = `DMEM_AW
) (
    input  logic             clk,
    input  logic             en_i,
    input  logic             we_i,
    input  logic [AW-1:0]    addr_i,
    input  logic [`XLEN-1:0] wdata_i,
    output logic [`XLEN-1:0] rdata_o
);

    logic [`XLEN-1:0] mem [2**AW];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];   // Old word on a write, stays until the next access
        end
    end

endmodule

//--- hdl/dmem_arbiter.sv
`include "backend_config.svh"

module dmem_arbiter (
    input  logic                clk,
    input  logic                arst_n_i,
    mem_req_if.arbiter          pipe,
    mem_req_if.arbiter          host,
    output logic                mem_en_o,
    output logic                mem_we_o,
    output logic [`DMEM_AW-1:0] mem_addr_o,
    output logic [`XLEN-1:0]    mem_wdata_o,
    input  logic [`XLEN-1:0]    mem_rdata_i
);

    backend_pkg::arb_state_e state_q;
    logic                    last_host_q;   // Also selects the requester in flight
    logic                    grant_host;
    logic                    sel_req;

    // On a tie the requester not served last wins
    assign grant_host = host.req && (!pipe.req || !last_host_q);
    assign sel_req    = last_host_q ? host.req : pipe.req;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= backend_pkg::ARB_IDLE;
            last_host_q <= 1'b0;
        end else begin
            case (state_q)
                backend_pkg::ARB_IDLE: begin
                    if (pipe.req || host.req) begin
                        last_host_q <= grant_host;
                        state_q     <= backend_pkg::ARB_READ;
                    end
                end
                backend_pkg::ARB_READ: begin
                    state_q <= backend_pkg::ARB_ACK;
                end
                backend_pkg::ARB_ACK: begin
                    if (!sel_req) begin
                        state_q <= backend_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state_q <= backend_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    assign mem_en_o    = (state_q == backend_pkg::ARB_READ);
    assign mem_we_o    = mem_en_o && (last_host_q ? host.we : pipe.we);
    assign mem_addr_o  = last_host_q ? host.addr : pipe.addr;
    assign mem_wdata_o = last_host_q ? host.wdata : pipe.wdata;

    // The memory output register keeps the word for the whole ack phase
    assign pipe.ack   = (state_q == backend_pkg::ARB_ACK) && !last_host_q;
    assign host.ack   = (state_q == backend_pkg::ARB_ACK) && last_host_q;
    assign pipe.rdata = mem_rdata_i;
    assign host.rdata = mem_rdata_i;

endmodule

//--- hdl/mem_stage.sv
`include "backend_config.svh"

module mem_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 ex_valid_i,
    output logic                 ready_o,
    input  logic [`XLEN-1:0]     ex_pc_i,
    input  logic [4:0]           ex_rd_i,
    input  logic                 ex_rf_wen_i,
    input  backend_pkg::wb_sel_e ex_wb_sel_i,
    input  logic [`XLEN-1:0]     ex_alu_out_i,
    input  logic [`XLEN-1:0]     ex_csr_rdata_i,
    mem_req_if.requester         mem,
    output logic                 mw_valid_o,
    output logic [`XLEN-1:0]     mw_pc_o,
    output logic [4:0]           mw_rd_o,
    output logic                 mw_rf_wen_o,
    output backend_pkg::wb_sel_e mw_wb_sel_o,
    output logic [`XLEN-1:0]     mw_alu_out_o,
    output logic [`XLEN-1:0]     mw_csr_rdata_o,
    output logic [`XLEN-1:0]     mw_mem_rdata_o
);

    backend_pkg::load_state_e state_q;
    logic                     req_q;
    logic                     accept;
    logic                     ex_is_load;

    assign ready_o    = (state_q == backend_pkg::LD_EMPTY) || (state_q == backend_pkg::LD_DONE);
    assign accept     = ex_valid_i && ready_o;
    assign ex_is_load = ex_wb_sel_i inside {backend_pkg::WB_MEMB, backend_pkg::WB_MEMBU,
                                            backend_pkg::WB_MEMH, backend_pkg::WB_MEMHU,
                                            backend_pkg::WB_MEMW};

    always_ff @(posedge clk) begin
        if (accept) begin
            mw_pc_o        <= ex_pc_i;
            mw_rd_o        <= ex_rd_i;
            mw_rf_wen_o    <= ex_rf_wen_i;
            mw_wb_sel_o    <= ex_wb_sel_i;
            mw_alu_out_o   <= ex_alu_out_i;
            mw_csr_rdata_o <= ex_csr_rdata_i;
        end
        if (req_q && mem.ack) begin
            mw_mem_rdata_o <= mem.rdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= backend_pkg::LD_EMPTY;
            req_q   <= 1'b0;
        end else begin
            case (state_q)
                backend_pkg::LD_EMPTY, backend_pkg::LD_DONE: begin
                    if (accept) begin
                        state_q <= ex_is_load ? backend_pkg::LD_HOLD : backend_pkg::LD_DONE;
                    end else begin
                        state_q <= backend_pkg::LD_EMPTY;
                    end
                end
                backend_pkg::LD_HOLD: begin
                    req_q   <= 1'b1;
                    state_q <= backend_pkg::LD_REQ;
                end
                backend_pkg::LD_REQ: begin
                    if (req_q && mem.ack) begin
                        req_q <= 1'b0;
                    end else if (!req_q && !mem.ack) begin
                        state_q <= backend_pkg::LD_DONE;   // Handshake closed, hand over
                    end
                end
                default: begin
                    state_q <= backend_pkg::LD_EMPTY;
                end
            endcase
        end
    end

    // Loads only, so the write side of the channel is tied off
    assign mem.req   = req_q;
    assign mem.we    = 1'b0;
    assign mem.addr  = mw_alu_out_o[`DMEM_AW+1:2];
    assign mem.wdata = '0;

    assign mw_valid_o = (state_q == backend_pkg::LD_DONE);

endmodule

//--- hdl/writeback_stage.sv
`include "backend_config.svh"

module writeback_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 mw_valid_i,
    input  logic [`XLEN-1:0]     mw_pc_i,
    input  logic [4:0]           mw_rd_i,
    input  logic                 mw_rf_wen_i,
    input  backend_pkg::wb_sel_e mw_wb_sel_i,
    input  logic [`XLEN-1:0]     mw_alu_out_i,
    input  logic [`XLEN-1:0]     mw_csr_rdata_i,
    input  logic [`XLEN-1:0]     mw_mem_rdata_i,
    output logic                 rf_we_o,
    output logic [4:0]           rf_waddr_o,
    output logic [`XLEN-1:0]     rf_wdata_o,
    output logic [`XLEN-1:0]     retire_count_o,
    output logic                 exit_o
);

    // Sub-word loads use the low part of the word whatever the byte offset
    always_comb begin
        case (mw_wb_sel_i)
            backend_pkg::WB_MEMB:  rf_wdata_o = {{24{mw_mem_rdata_i[7]}}, mw_mem_rdata_i[7:0]};
            backend_pkg::WB_MEMBU: rf_wdata_o = {24'b0, mw_mem_rdata_i[7:0]};
            backend_pkg::WB_MEMH:  rf_wdata_o = {{16{mw_mem_rdata_i[15]}}, mw_mem_rdata_i[15:0]};
            backend_pkg::WB_MEMHU: rf_wdata_o = {16'b0, mw_mem_rdata_i[15:0]};
            backend_pkg::WB_MEMW:  rf_wdata_o = mw_mem_rdata_i;
            backend_pkg::WB_PC:    rf_wdata_o = mw_pc_i + 32'd4;
            backend_pkg::WB_CSR:   rf_wdata_o = mw_csr_rdata_i;
            default:               rf_wdata_o = mw_alu_out_i;
        endcase
    end

    assign rf_we_o    = mw_valid_i && mw_rf_wen_i;
    assign rf_waddr_o = mw_rd_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_count_o <= '0;
            exit_o         <= 1'b0;
        end else if (mw_valid_i) begin
            retire_count_o <= retire_count_o + 1'b1;
            if (mw_pc_i == `EXIT_PC) begin
                exit_o <= 1'b1;   // Sticky until reset
            end
        end
    end

endmodule

//--- hdl/reg_file.sv
`include "backend_config.svh"

module reg_file (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             we_i,
    input  logic [4:0]       waddr_i,
    input  logic [`XLEN-1:0] wdata_i,
    input  logic [4:0]       raddr_a_i,
    input  logic [4:0]       raddr_b_i,
    output logic [`XLEN-1:0] rdata_a_o,
    output logic [`XLEN-1:0] rdata_b_o
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= (i == 2) ? `SP_RESET : '0;   // x2 starts as the stack pointer
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is never written, so it reads as zero
    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

endmodule

//--- hdl/wb_backend_top.sv
`include "backend_config.svh"

module wb_backend_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 ex_valid_i,
    output logic                 ready_o,
    input  logic [`XLEN-1:0]     ex_pc_i,
    input  logic [4:0]           ex_rd_i,
    input  logic                 ex_rf_wen_i,
    input  backend_pkg::wb_sel_e ex_wb_sel_i,
    input  logic [`XLEN-1:0]     ex_alu_out_i,
    input  logic [`XLEN-1:0]     ex_csr_rdata_i,
    input  logic                 host_req_i,
    input  logic                 host_we_i,
    input  logic [`DMEM_AW-1:0]  host_addr_i,
    input  logic [`XLEN-1:0]     host_wdata_i,
    output logic                 host_ack_o,
    output logic [`XLEN-1:0]     host_rdata_o,
    input  logic [4:0]           rs1_addr_i,
    input  logic [4:0]           rs2_addr_i,
    output logic [`XLEN-1:0]     rs1_data_o,
    output logic [`XLEN-1:0]     rs2_data_o,
    output logic [`XLEN-1:0]     retire_count_o,
    output logic                 exit_o
);

    mem_req_if pipe_req ();
    mem_req_if host_req ();

    logic                 mw_valid;
    logic [`XLEN-1:0]     mw_pc;
    logic [4:0]           mw_rd;
    logic                 mw_rf_wen;
    backend_pkg::wb_sel_e mw_wb_sel;
    logic [`XLEN-1:0]     mw_alu_out;
    logic [`XLEN-1:0]     mw_csr_rdata;
    logic [`XLEN-1:0]     mw_mem_rdata;

    logic                 mem_en;
    logic                 mem_we;
    logic [`DMEM_AW-1:0]  mem_addr;
    logic [`XLEN-1:0]     mem_wdata;
    logic [`XLEN-1:0]     mem_rdata;

    logic                 rf_we;
    logic [4:0]           rf_waddr;
    logic [`XLEN-1:0]     rf_wdata;

    assign host_req.req   = host_req_i;
    assign host_req.we    = host_we_i;
    assign host_req.addr  = host_addr_i;
    assign host_req.wdata = host_wdata_i;
    assign host_ack_o     = host_req.ack;
    assign host_rdata_o   = host_req.rdata;

    mem_stage u_mem_stage (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .ex_valid_i     (ex_valid_i),
        .ready_o        (ready_o),
        .ex_pc_i        (ex_pc_i),
        .ex_rd_i        (ex_rd_i),
        .ex_rf_wen_i    (ex_rf_wen_i),
        .ex_wb_sel_i    (ex_wb_sel_i),
        .ex_alu_out_i   (ex_alu_out_i),
        .ex_csr_rdata_i (ex_csr_rdata_i),
        .mem            (pipe_req.requester),
        .mw_valid_o     (mw_valid),
        .mw_pc_o        (mw_pc),
        .mw_rd_o        (mw_rd),
        .mw_rf_wen_o    (mw_rf_wen),
        .mw_wb_sel_o    (mw_wb_sel),
        .mw_alu_out_o   (mw_alu_out),
        .mw_csr_rdata_o (mw_csr_rdata),
        .mw_mem_rdata_o (mw_mem_rdata)
    );

    dmem_arbiter u_dmem_arbiter (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pipe        (pipe_req.arbiter),
        .host        (host_req.arbiter),
        .mem_en_o    (mem_en),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata)
    );

    data_mem #(
        .AW (`DMEM_AW)
    ) u_data_mem (
        .clk     (clk),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    writeback_stage u_writeback_stage (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .mw_valid_i     (mw_valid),
        .mw_pc_i        (mw_pc),
        .mw_rd_i        (mw_rd),
        .mw_rf_wen_i    (mw_rf_wen),
        .mw_wb_sel_i    (mw_wb_sel),
        .mw_alu_out_i   (mw_alu_out),
        .mw_csr_rdata_i (mw_csr_rdata),
        .mw_mem_rdata_i (mw_mem_rdata),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .retire_count_o (retire_count_o),
        .exit_o         (exit_o)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .raddr_a_i (rs1_addr_i),
        .raddr_b_i (rs2_addr_i),
        .rdata_a_o (rs1_data_o),
        .rdata_b_o (rs2_data_o)
    );

endmodule

//--- bench/tb_wb_backend.sv
`include "backend_config.svh"

module tb_wb_backend;

    localparam int DRIVE_DELAY = 2;
    localparam int N_INSTR     = 44;               // Random, x0 and exit-PC instructions
    localparam int N_HOST_OPS  = 72;
    localparam int N_LOADS     = 15;
    localparam int N_REG_READS = 4 * 32;
    localparam int WORST_LAT   = 16;               // Host access stuck behind a load plus margin
    localparam int LOAD_BUSY   = 6;                // Shortest load keeps ready low for six edges
    localparam int TIMEOUT_CYCLES = (N_INSTR + N_HOST_OPS + N_LOADS + N_REG_READS) * WORST_LAT;

    logic                 clk;
    logic                 arst_n_i;
    logic                 ex_valid_i;
    logic                 ready_o;
    logic [`XLEN-1:0]     ex_pc_i;
    logic [4:0]           ex_rd_i;
    logic                 ex_rf_wen_i;
    backend_pkg::wb_sel_e ex_wb_sel_i;
    logic [`XLEN-1:0]     ex_alu_out_i;
    logic [`XLEN-1:0]     ex_csr_rdata_i;
    logic                 host_req_i;
    logic                 host_we_i;
    logic [`DMEM_AW-1:0]  host_addr_i;
    logic [`XLEN-1:0]     host_wdata_i;
    logic                 host_ack_o;
    logic [`XLEN-1:0]     host_rdata_o;
    logic [4:0]           rs1_addr_i;
    logic [4:0]           rs2_addr_i;
    logic [`XLEN-1:0]     rs1_data_o;
    logic [`XLEN-1:0]     rs2_data_o;
    logic [`XLEN-1:0]     retire_count_o;
    logic                 exit_o;

    logic [`XLEN-1:0] reg_model [32];
    logic [`XLEN-1:0] mem_model [2**`DMEM_AW];
    logic [`XLEN-1:0] exp_count;
    logic             exp_exit;
    logic [`XLEN-1:0] exp_rs1;
    logic [`XLEN-1:0] exp_rs2;
    logic [`XLEN-1:0] exp_host_rdata;
    logic             chk_rf;
    logic             chk_status;
    logic             chk_reset;
    logic             chk_busy;
    logic             chk_host_hold;
    logic             host_rd_check;
    logic             host_busy;
    int               seed;
    int               cycles = 0;

    backend_pkg::wb_sel_e load_kinds [5] = '{backend_pkg::WB_MEMB, backend_pkg::WB_MEMBU,
        backend_pkg::WB_MEMH, backend_pkg::WB_MEMHU, backend_pkg::WB_MEMW};

    wb_backend_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_mismatch(input string name, input logic [`XLEN-1:0] expected,
                                    input logic [`XLEN-1:0] actual);
        $display("MISMATCH %s expected %h got %h", name, expected, actual);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic stop_with(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_with("Timeout, the run went past its cycle limit");
        end
    end

    a_rs1: assert property (@(posedge clk) chk_rf |-> rs1_data_o == exp_rs1)
        else stop_on_mismatch("rs1_data_o", $sampled(exp_rs1), $sampled(rs1_data_o));
    a_rs2: assert property (@(posedge clk) chk_rf |-> rs2_data_o == exp_rs2)
        else stop_on_mismatch("rs2_data_o", $sampled(exp_rs2), $sampled(rs2_data_o));
    a_count: assert property (@(posedge clk) chk_status |-> retire_count_o == exp_count)
        else stop_on_mismatch("retire_count_o", $sampled(exp_count), $sampled(retire_count_o));
    a_exit: assert property (@(posedge clk) chk_status |-> exit_o == exp_exit)
        else stop_on_mismatch("exit_o", 32'($sampled(exp_exit)), 32'($sampled(exit_o)));
    a_reset_ready: assert property (@(posedge clk) chk_reset |-> ready_o)
        else stop_on_mismatch("ready_o", 32'h1, 32'($sampled(ready_o)));
    a_reset_ack: assert property (@(posedge clk) chk_reset |-> !host_ack_o)
        else stop_on_mismatch("host_ack_o", 32'h0, 32'($sampled(host_ack_o)));
    a_load_busy: assert property (@(posedge clk) chk_busy |-> !ready_o)
        else stop_on_mismatch("ready_o", 32'h0, 32'($sampled(ready_o)));
    a_host_hold: assert property (@(posedge clk) chk_host_hold |-> host_ack_o)
        else stop_on_mismatch("host_ack_o", 32'h1, 32'($sampled(host_ack_o)));
    a_host_rdata: assert property (@(posedge clk)
        chk_host_hold && host_rd_check |-> host_rdata_o == exp_host_rdata)
        else stop_on_mismatch("host_rdata_o", $sampled(exp_host_rdata), $sampled(host_rdata_o));
    a_host_spurious: assert property (@(posedge clk) host_ack_o |-> host_busy)
        else stop_with("Host ack went high with no host request pending");

    function automatic logic is_load(input backend_pkg::wb_sel_e sel);
        case (sel)
            backend_pkg::WB_MEMB, backend_pkg::WB_MEMBU, backend_pkg::WB_MEMH,
            backend_pkg::WB_MEMHU, backend_pkg::WB_MEMW: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Sub-word loads take the low part of the word
    function automatic logic [`XLEN-1:0] model_result(input backend_pkg::wb_sel_e sel,
        input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] alu,
        input logic [`XLEN-1:0] csr, input logic [`XLEN-1:0] word);
        case (sel)
            backend_pkg::WB_MEMB:  return 32'($signed(word[7:0]));
            backend_pkg::WB_MEMBU: return word & 32'h0000_00ff;
            backend_pkg::WB_MEMH:  return 32'($signed(word[15:0]));
            backend_pkg::WB_MEMHU: return word & 32'h0000_ffff;
            backend_pkg::WB_MEMW:  return word;
            backend_pkg::WB_PC:    return pc + 32'd4;
            backend_pkg::WB_CSR:   return csr;
            default:               return alu;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Pipeline is empty and the last result sits in the register file
    task automatic settle();
        while (!ready_o) next_cycle();
        next_cycle();
    endtask

    task automatic issue(input logic [`XLEN-1:0] pc, input logic [4:0] rd, input logic wen,
                         input backend_pkg::wb_sel_e sel, input logic [`XLEN-1:0] alu,
                         input logic [`XLEN-1:0] csr);
        logic [`XLEN-1:0] word;
        word = mem_model[alu[`DMEM_AW+1:2]];
        while (!ready_o) next_cycle();
        ex_valid_i     = 1'b1;
        ex_pc_i        = pc;
        ex_rd_i        = rd;
        ex_rf_wen_i    = wen;
        ex_wb_sel_i    = sel;
        ex_alu_out_i   = alu;
        ex_csr_rdata_i = csr;
        next_cycle();                              // Accepted at this edge
        ex_valid_i = 1'b0;
        exp_count  = exp_count + 32'd1;
        if (pc == `EXIT_PC) exp_exit = 1'b1;
        if (wen && rd != 5'd0) reg_model[rd] = model_result(sel, pc, alu, csr, word);
        if (is_load(sel)) begin
            chk_busy = 1'b1;
            repeat (LOAD_BUSY) next_cycle();
            chk_busy = 1'b0;
            while (!ready_o) next_cycle();
        end
    endtask

    task automatic issue_random();
        backend_pkg::wb_sel_e sel;
        int pick;
        pick = $random(seed) & 3;
        case (pick)
            0: sel = backend_pkg::WB_PC;
            1: sel = backend_pkg::WB_CSR;
            default: sel = backend_pkg::WB_ALU;
        endcase
        issue($random(seed) & 32'h0000_fffc, 5'($random(seed)), ($random(seed) & 7) != 0,
              sel, $random(seed), $random(seed));
    endtask

    task automatic check_one_reg(input logic [4:0] rd);
        rs1_addr_i = rd;
        rs2_addr_i = rd;
        exp_rs1    = reg_model[rd];
        exp_rs2    = reg_model[rd];
        chk_rf     = 1'b1;
        next_cycle();
        chk_rf     = 1'b0;
    endtask

    task automatic check_regs();
        chk_rf = 1'b1;
        for (int i = 0; i < 32; i++) begin
            rs1_addr_i = 5'(i);
            rs2_addr_i = 5'(31 - i);
            exp_rs1    = reg_model[i];
            exp_rs2    = reg_model[31 - i];
            next_cycle();
        end
        chk_rf = 1'b0;
    endtask

    task automatic check_status();
        chk_status = 1'b1;
        next_cycle();
        chk_status = 1'b0;
    endtask

    task automatic load_and_check(input backend_pkg::wb_sel_e sel,
                                  input logic [`DMEM_AW-1:0] addr);
        logic [4:0]       rd;
        logic [`XLEN-1:0] alu;
        rd  = 5'd8 + 5'($random(seed) & 15);
        alu = {{(`XLEN-`DMEM_AW-2){1'b0}}, addr, 2'($random(seed))};   // Offset bits are ignored
        issue(alu, rd, 1'b1, sel, alu, 32'h0);
        next_cycle();
        check_one_reg(rd);
    endtask

    // Four-phase host access that checks read data while ack is held
    task automatic host_access(input logic we, input logic [`DMEM_AW-1:0] addr,
                               input logic [`XLEN-1:0] wdata);
        host_busy    = 1'b1;
        host_req_i   = 1'b1;
        host_we_i    = we;
        host_addr_i  = addr;
        host_wdata_i = wdata;
        next_cycle();
        while (!host_ack_o) next_cycle();
        exp_host_rdata = mem_model[addr];
        host_rd_check  = !we;
        chk_host_hold  = 1'b1;
        next_cycle();
        host_req_i = 1'b0;
        next_cycle();                              // The edge that first sees req low
        chk_host_hold = 1'b0;
        while (host_ack_o) next_cycle();
        host_busy = 1'b0;
        if (we) mem_model[addr] = wdata;
    endtask

    task automatic host_traffic();
        for (int a = 32; a < 48; a++) host_access(1'b1, `DMEM_AW'(a), $random(seed));
        for (int a = 32; a < 48; a++) host_access(1'b0, `DMEM_AW'(a), '0);
    endtask

    initial begin
        seed           = 32'hf787;
        arst_n_i       = 1'b1;
        ex_valid_i     = 1'b0;
        ex_pc_i        = '0;
        ex_rd_i        = '0;
        ex_rf_wen_i    = 1'b0;
        ex_wb_sel_i    = backend_pkg::WB_ALU;
        ex_alu_out_i   = '0;
        ex_csr_rdata_i = '0;
        host_req_i     = 1'b0;
        host_we_i      = 1'b0;
        host_addr_i    = '0;
        host_wdata_i   = '0;
        rs1_addr_i     = '0;
        rs2_addr_i     = '0;
        chk_rf         = 1'b0;
        chk_status     = 1'b0;
        chk_reset      = 1'b0;
        chk_busy       = 1'b0;
        chk_host_hold  = 1'b0;
        host_rd_check  = 1'b0;
        host_busy      = 1'b0;
        exp_count = '0;
        exp_exit  = 1'b0;
        for (int i = 0; i < 32; i++) reg_model[i] = (i == 2) ? `SP_RESET : '0;
        #1 arst_n_i = 1'b0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY arst_n_i = 1'b1;

        chk_reset = 1'b1;
        check_status();
        chk_reset = 1'b0;
        check_regs();

        for (int n = 0; n < N_INSTR - 4; n++) issue_random();
        issue(32'h0000_0040, 5'd0, 1'b1, backend_pkg::WB_ALU, 32'hdead_beef, 32'h0);
        settle();
        check_regs();
        check_status();

        // Words 0 and 1 cover both sign cases of every sub-word load
        for (int a = 0; a < 32; a++) begin
            host_access(1'b1, `DMEM_AW'(a), (a == 0) ? 32'hfedc_ba98 :
                        (a == 1) ? 32'h0123_4567 : $random(seed));
        end
        for (int n = 0; n < 8; n++) host_access(1'b0, `DMEM_AW'($random(seed) & 31), '0);

        for (int k = 0; k < 10; k++) load_and_check(load_kinds[k % 5], `DMEM_AW'(k / 5));

        fork
            for (int k = 0; k < 5; k++) begin
                load_and_check(load_kinds[k], `DMEM_AW'($random(seed) & 31));
            end
            host_traffic();
        join
        settle();
        check_regs();
        check_status();

        issue(`EXIT_PC, 5'd5, 1'b1, backend_pkg::WB_PC, 32'h0, 32'h0);
        issue_random();
        issue_random();
        settle();
        check_regs();
        check_status();

        $display("test passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+hdl
hdl/backend_pkg.sv
hdl/mem_req_if.sv
hdl/data_mem.sv
hdl/dmem_arbiter.sv
hdl/mem_stage.sv
hdl/writeback_stage.sv
hdl/reg_file.sv
hdl/wb_backend_top.sv
bench/tb_wb_backend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status carries pass or fail.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_wb_backend -f sim.f -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0
